//--- vector_input.txt
0 00000020 a1b2c3d4 00000000 00000000 0
2 00000020 00000011 00000000 00000000 0
2 00000021 00000022 00000000 00000000 0
2 00000022 00000033 00000000 00000000 0
2 00000023 00000044 00000000 00000000 0
5 00000020 00000000 00000000 44332211 0
1 00000020 00005566 00000000 00000000 0
1 00000022 00008877 00000000 00000000 0
5 00000020 00000000 00000000 88775566 0
8 00000023 00000000 00000000 ffffff88 0
9 00000023 00000000 00000000 00000088 0
6 00000022 00000000 00000000 ffff8877 0
7 00000022 00000000 00000000 00008877 0
a 00000020 00000000 aabbccdd 66bbccdd 0
a 00000021 00000000 aabbccdd 5566ccdd 0
a 00000022 00000000 aabbccdd 775566dd 0
a 00000023 00000000 aabbccdd 88775566 0
b 00000020 00000000 aabbccdd 88775566 0
b 00000021 00000000 aabbccdd aa887755 0
b 00000022 00000000 aabbccdd aabb8877 0
b 00000023 00000000 aabbccdd aabbcc88 0
3 00000043 11223344 00000000 00000000 0
5 00000040 00000000 00000000 11223344 0
3 00000042 55667788 00000000 00000000 0
5 00000040 00000000 00000000 11556677 0
3 00000041 99aabbcc 00000000 00000000 0
5 00000040 00000000 00000000 115599aa 0
3 00000040 ddeeff01 00000000 00000000 0
5 00000040 00000000 00000000 115599dd 0
4 00000044 11223344 00000000 00000000 0
5 00000044 00000000 00000000 11223344 0
4 00000045 55667788 00000000 00000000 0
5 00000044 00000000 00000000 66778844 0
4 00000046 99aabbcc 00000000 00000000 0
5 00000044 00000000 00000000 bbcc8844 0
4 00000047 ddeeff01 00000000 00000000 0
5 00000044 00000000 00000000 01cc8844 0
c 00000000 00000001 00000000 00000000 0
d 00000000 00000000 00000000 00000001 0
0 00000022 deadbeef 00000000 00000000 1
5 00000020 00000000 00000000 88775566 0
6 00000021 00000000 00000000 00000000 1
d 00000004 00000000 00000000 00000002 0
d 00000008 00000000 00000000 00000021 0
c 00000000 00000000 00000000 00000000 0
1 00000021 0000abcd 00000000 00000000 0
5 00000020 00000000 00000000 8877abcd 0
d 00000004 00000000 00000000 00000002 0
c 00000004 00000000 00000000 00000000 0
d 00000004 00000000 00000000 00000000 0

//--- mipsMemStage.f
memStagePkg.sv
storeAlign.sv
loadAlign.sv
accessCheck.sv
dataRam.sv
memStageRegs.sv
mipsMemStage.sv
tb_mipsMemStage.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mipsMemStage -f mipsMemStage.f -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb_mipsMemStage.sv
// testbench for the MIPS memory stage, driven and checked from a vector file
`timescale 1ns/10ps
`default_nettype none

module tb_mipsMemStage import memStagePkg::*; ();

  localparam int ADDR_WIDTH = 8;
  localparam int WAIT_LIMIT = 20; // cycles before any wait gives up

  // vector op codes
  localparam logic [3:0] OP_SW    = 4'h0;
  localparam logic [3:0] OP_SH    = 4'h1;
  localparam logic [3:0] OP_SB    = 4'h2;
  localparam logic [3:0] OP_SWL   = 4'h3;
  localparam logic [3:0] OP_SWR   = 4'h4;
  localparam logic [3:0] OP_LW    = 4'h5;
  localparam logic [3:0] OP_LH    = 4'h6;
  localparam logic [3:0] OP_LHU   = 4'h7;
  localparam logic [3:0] OP_LB    = 4'h8;
  localparam logic [3:0] OP_LBU   = 4'h9;
  localparam logic [3:0] OP_LWL   = 4'ha;
  localparam logic [3:0] OP_LWR   = 4'hb;
  localparam logic [3:0] OP_APBWR = 4'hc; // addr is the offset, wdata the value
  localparam logic [3:0] OP_APBRD = 4'hd; // expected holds the read value

  logic        clk;
  logic        rstN;
  logic        reqValid;
  memReq_t     req;
  logic        loadValid;
  logic [31:0] loadData;
  logic        addrErr;
  logic [3:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          errors;

  mipsMemStage #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_dut (
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .req       (req),
    .loadValid (loadValid),
    .loadData  (loadData),
    .addrErr   (addrErr),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  function automatic string opLabel(input logic [3:0] op);
    case (op)
      OP_SW:    return "sw";
      OP_SH:    return "sh";
      OP_SB:    return "sb";
      OP_SWL:   return "swl";
      OP_SWR:   return "swr";
      OP_LW:    return "lw";
      OP_LH:    return "lh";
      OP_LHU:   return "lhu";
      OP_LB:    return "lb";
      OP_LBU:   return "lbu";
      OP_LWL:   return "lwl";
      OP_LWR:   return "lwr";
      OP_APBWR: return "apb write";
      OP_APBRD: return "apb read";
      default:  return "unknown op";
    endcase
  endfunction

  function automatic memReq_t buildReq(input logic [3:0] op, input logic [31:0] addr,
                                       input logic [31:0] wdata, input logic [31:0] rtOld);
    memReq_t r;
    r       = '0;
    r.addr  = addr;
    r.wdata = wdata;
    r.rtOld = rtOld;
    case (op)
      OP_SW:   r.storeType = '{1'b1, 2'b00, STORE_SW};
      OP_SH:   r.storeType = '{1'b1, 2'b00, STORE_SH};
      OP_SB:   r.storeType = '{1'b1, 2'b00, STORE_SB};
      OP_SWL:  r.storeType = '{1'b1, 2'b10, STORE_SW};
      OP_SWR:  r.storeType = '{1'b1, 2'b01, STORE_SW};
      OP_LW:   r.loadType  = '{1'b1, 2'b00, LOAD_LW, 1'b0};
      OP_LH:   r.loadType  = '{1'b1, 2'b00, LOAD_LH, 1'b1};
      OP_LHU:  r.loadType  = '{1'b1, 2'b00, LOAD_LH, 1'b0};
      OP_LB:   r.loadType  = '{1'b1, 2'b00, LOAD_LB, 1'b1};
      OP_LBU:  r.loadType  = '{1'b1, 2'b00, LOAD_LB, 1'b0};
      OP_LWL:  r.loadType  = '{1'b1, 2'b10, LOAD_LW, 1'b0};
      OP_LWR:  r.loadType  = '{1'b1, 2'b01, LOAD_LW, 1'b0};
      default: r = '0;
    endcase
    return r;
  endfunction

  // setup, access, then wait for pready
  task automatic apbTransfer(input string name, input logic write, input logic [3:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= data;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    waited = 0;
    while (!pready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      $display("APB transfer to offset %h never saw pready", addr);
      errors++;
    end
    checkValue({name, " pslverr"}, 32'd0, {31'b0, pslverr});
    rdata = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic memAccess(input string name, input logic [3:0] op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rtOld,
                           input logic [31:0] expected, input logic expErr);
    logic isLoad;
    logic validSeen;
    int   waited;
    isLoad = (op >= OP_LW) && (op <= OP_LWR);
    @(posedge clk);
    req      <= buildReq(op, addr, wdata, rtOld);
    reqValid <= 1'b1;
    @(posedge clk); // DUT samples the request here
    reqValid <= 1'b0;
    @(negedge clk);
    validSeen = loadValid;
    checkValue({name, " addrErr"}, {31'b0, expErr}, {31'b0, addrErr});
    if (!isLoad || expErr) begin
      checkValue({name, " loadValid"}, 32'd0, {31'b0, validSeen});
    end else begin
      waited = 1;
      while (!loadValid && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (!loadValid) begin
        $display("%s: no loadValid within %0d cycles", name, WAIT_LIMIT);
        errors++;
      end else begin
        checkValue({name, " latency"}, 32'd1, waited);
        checkValue({name, " loadData"}, expected, loadData);
      end
    end
  endtask

  task automatic runVector(input int vecNo, input logic [3:0] op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rtOld,
                           input logic [31:0] expected, input logic expErr);
    string       name;
    logic [31:0] rdata;
    name = $sformatf("vector %0d %s", vecNo, opLabel(op));
    if (op == OP_APBWR) begin
      apbTransfer(name, 1'b1, addr[3:0], wdata, rdata);
    end else if (op == OP_APBRD) begin
      apbTransfer(name, 1'b0, addr[3:0], 32'd0, rdata);
      checkValue(name, expected, rdata);
    end else if (op <= OP_LWR) begin
      memAccess(name, op, addr, wdata, rtOld, expected, expErr);
    end else begin
      $display("%s: op code %h is not defined", name, op);
      errors++;
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          vecNo;
    logic        done;
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rtOld;
    logic [31:0] expected;
    logic [3:0]  expErr;
    errors   = 0;
    vecNo    = 0;
    rstN     = 1'b0;
    reqValid = 1'b0;
    req      = '0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    fd = $fopen("vector_input.txt", "r");
    if (fd == 0) begin
      $display("could not open vector_input.txt");
      errors++;
    end else begin
      done = 1'b0;
      while (!done) begin
        n = $fscanf(fd, "%h %h %h %h %h %h", op, addr, wdata, rtOld, expected, expErr);
        if (n == 6) begin
          vecNo++;
          runVector(vecNo, op, addr, wdata, rtOld, expected, expErr[0]);
        end else begin
          if (n > 0) begin
            $display("vector %0d is incomplete in vector_input.txt", vecNo + 1);
            errors++;
          end
          done = 1'b1;
        end
      end
      $fclose(fd);
      if (vecNo == 0) begin
        $display("vector_input.txt holds no vectors");
        errors++;
      end
    end
    $display("errors: %0d in %0d vectors", errors, vecNo);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mipsMemStage.sv
// MIPS memory stage top with store/load alignment, data RAM and error registers
`timescale 1ns/10ps
`default_nettype none

module mipsMemStage import memStagePkg::*; #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        reqValid,
  input  memReq_t     req,
  output logic        loadValid,
  output logic [31:0] loadData,
  output logic        addrErr,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic        misaligned;
  logic        errEnable;
  logic        blockAcc;
  logic        errPulse;
  logic        loadGo;
  logic [3:0]  alignWen;
  logic [3:0]  ramWen;
  logic [31:0] storeData;
  logic [31:0] ramWord;
  loadCtx_t    ctxQ;

  assign blockAcc = errEnable & misaligned; // suppress faulting access
  assign errPulse = reqValid & blockAcc;
  assign loadGo   = reqValid & req.loadType.dmRd & ~blockAcc;
  assign ramWen   = (reqValid && !blockAcc) ? alignWen : 4'b0000;

  accessCheck i_accessCheck (
    .req        (req),
    .misaligned (misaligned)
  );

  storeAlign i_storeAlign (
    .storeType (req.storeType),
    .addrLow   (req.addr[1:0]),
    .wdata     (req.wdata),
    .byteWen   (alignWen),
    .storeData (storeData)
  );

  dataRam #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_dataRam (
    .clk      (clk),
    .wordAddr (req.addr[ADDR_WIDTH+1:2]),
    .byteWen  (ramWen),
    .wdata    (storeData),
    .rdEn     (loadGo),
    .rdata    (ramWord)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      loadValid <= 1'b0;
      addrErr   <= 1'b0;
    end else begin
      loadValid <= loadGo;
      addrErr   <= errPulse;
    end
  end

  // load context rides alongside the ram read
  always_ff @(posedge clk) begin
    if (loadGo) begin
      ctxQ.loadType <= req.loadType;
      ctxQ.addrLow  <= req.addr[1:0];
      ctxQ.rtOld    <= req.rtOld;
    end
  end

  loadAlign i_loadAlign (
    .ctx      (ctxQ),
    .ramWord  (ramWord),
    .loadData (loadData)
  );

  memStageRegs i_memStageRegs (
    .clk       (clk),
    .rstN      (rstN),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .errPulse  (errPulse),
    .errAddr   (req.addr),
    .errEnable (errEnable)
  );

  loadOrStore: assert property (@(posedge clk) disable iff (!rstN)
    reqValid |-> !(req.storeType.dmWr && req.loadType.dmRd))
    else $error("mipsMemStage: load and store in one request");

endmodule

`default_nettype wire

//--- memStageRegs.sv
// APB register block with error enable, saturating error count and bad address
`timescale 1ns/10ps
`default_nettype none

module memStageRegs import memStagePkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        errPulse,
  input  logic [31:0] errAddr,
  output logic        errEnable
);

  logic        wrEn;
  logic [15:0] errCount;
  logic [31:0] badAddr;

  assign wrEn    = psel & penable & pwrite; // access phase write
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      errEnable <= 1'b0;
      errCount  <= '0;
      badAddr   <= '0;
    end else begin
      if (wrEn && (paddr == REG_CTRL)) begin
        errEnable <= pwdata[0];
      end
      if (wrEn && (paddr == REG_ERRCNT)) begin
        errCount <= {15'b0, errPulse}; // clear, then count this one
      end else if (errPulse && (errCount != 16'hffff)) begin
        errCount <= errCount + 16'd1;
      end
      if (errPulse) begin
        badAddr <= errAddr;
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        REG_CTRL:    prdata = {31'b0, errEnable};
        REG_ERRCNT:  prdata = {16'b0, errCount};
        REG_BADADDR: prdata = badAddr;
        default:     prdata = '0;
      endcase
    end
  end

  penableNeedsPsel: assert property (@(posedge clk) disable iff (!rstN)
    penable |-> psel)
    else $error("memStageRegs: penable without psel");

endmodule

`default_nettype wire

//--- dataRam.sv
// word-wide data RAM with byte write enables and a registered read port
`timescale 1ns/10ps
`default_nettype none

module dataRam #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] wordAddr,
  input  logic [3:0]            byteWen,
  input  logic [31:0]           wdata,
  input  logic                  rdEn,
  output logic [31:0]           rdata
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [31:0] mem [DEPTH];

  // per-byte write
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (byteWen[i]) begin
        mem[wordAddr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdata <= mem[wordAddr];
    end
  end

endmodule

`default_nettype wire

//--- accessCheck.sv
// MIPS address error check for misaligned halfword and word accesses
`timescale 1ns/10ps
`default_nettype none

module accessCheck import memStagePkg::*; (
  input  memReq_t req,
  output logic    misaligned
);

  logic plainStore;
  logic plainLoad;
  logic halfOdd;
  logic wordOff;
  logic storeBad;
  logic loadBad;

  // partial-word kinds never fault
  assign plainStore = req.storeType.dmWr && (req.storeType.leftOrRight == 2'b00);
  assign plainLoad  = req.loadType.dmRd && (req.loadType.leftOrRight == 2'b00);

  assign halfOdd = req.addr[0];
  assign wordOff = req.addr[1:0] != 2'b00;

  assign storeBad = plainStore &&
                    (((req.storeType.size == STORE_SH) && halfOdd) ||
                     ((req.storeType.size == STORE_SW) && wordOff));
  assign loadBad  = plainLoad &&
                    (((req.loadType.size == LOAD_LH) && halfOdd) ||
                     ((req.loadType.size == LOAD_LW) && wordOff));

  assign misaligned = storeBad | loadBad;

endmodule

`default_nettype wire

//--- loadAlign.sv
// load aligner with byte/half extraction, sign or zero extension and lwl/lwr merge
`timescale 1ns/10ps
`default_nettype none

module loadAlign import memStagePkg::*; (
  input  loadCtx_t    ctx,
  input  logic [31:0] ramWord,
  output logic [31:0] loadData
);

  logic [7:0]  byteSel;
  logic [15:0] halfSel;
  logic [31:0] rtOld;

  assign rtOld   = ctx.rtOld;
  assign byteSel = ramWord[{ctx.addrLow, 3'b000} +: 8];
  assign halfSel = ctx.addrLow[1] ? ramWord[31:16] : ramWord[15:0];

  always_comb begin
    loadData = ramWord;
    case (ctx.loadType.leftOrRight)
      2'b10: begin // lwl, fills high bytes of rt
        case (ctx.addrLow)
          2'b00:   loadData = {ramWord[7:0], rtOld[23:0]};
          2'b01:   loadData = {ramWord[15:0], rtOld[15:0]};
          2'b10:   loadData = {ramWord[23:0], rtOld[7:0]};
          default: loadData = ramWord;
        endcase
      end
      2'b01: begin // lwr, fills low bytes of rt
        case (ctx.addrLow)
          2'b00:   loadData = ramWord;
          2'b01:   loadData = {rtOld[31:24], ramWord[31:8]};
          2'b10:   loadData = {rtOld[31:16], ramWord[31:16]};
          default: loadData = {rtOld[31:8], ramWord[31:24]};
        endcase
      end
      2'b00: begin
        case (ctx.loadType.size)
          LOAD_LW: loadData = ramWord;
          LOAD_LH: begin
            if (ctx.loadType.sign) begin
              loadData = {{16{halfSel[15]}}, halfSel};
            end else begin
              loadData = {16'b0, halfSel};
            end
          end
          LOAD_LB: begin
            if (ctx.loadType.sign) begin
              loadData = {{24{byteSel[7]}}, byteSel};
            end else begin
              loadData = {24'b0, byteSel};
            end
          end
          default: loadData = ramWord;
        endcase
      end
      default: loadData = ramWord; // 11 is not a load kind
    endcase
  end

endmodule

`default_nettype wire

//--- storeAlign.sv
// store aligner producing byte enables and placed data for sb, sh, sw, swl and swr
`timescale 1ns/10ps
`default_nettype none

module storeAlign import memStagePkg::*; (
  input  storeType_t  storeType,
  input  logic [1:0]  addrLow,
  input  logic [31:0] wdata,
  output logic [3:0]  byteWen,
  output logic [31:0] storeData
);

  always_comb begin
    byteWen   = 4'b0000;
    storeData = '0;
    if (storeType.dmWr) begin
      case (storeType.leftOrRight)
        2'b10: begin // swl, high bytes of rt at and below addr
          case (addrLow)
            2'b00: begin
              byteWen   = 4'b0001;
              storeData = {24'b0, wdata[31:24]};
            end
            2'b01: begin
              byteWen   = 4'b0011;
              storeData = {16'b0, wdata[31:16]};
            end
            2'b10: begin
              byteWen   = 4'b0111;
              storeData = {8'b0, wdata[31:8]};
            end
            default: begin
              byteWen   = 4'b1111;
              storeData = wdata;
            end
          endcase
        end
        2'b01: begin // swr, low bytes of rt at and above addr
          byteWen   = 4'b1111 << addrLow;
          storeData = wdata << {addrLow, 3'b000};
        end
        2'b00: begin
          case (storeType.size)
            STORE_SW: begin
              byteWen   = 4'b1111;
              storeData = wdata;
            end
            STORE_SH: begin // only addr[1] picks the half
              byteWen   = addrLow[1] ? 4'b1100 : 4'b0011;
              storeData = {wdata[15:0], wdata[15:0]};
            end
            STORE_SB: begin
              byteWen   = 4'b0001 << addrLow;
              storeData = {4{wdata[7:0]}};
            end
            default: begin
              byteWen   = 4'b0000;
              storeData = '0;
            end
          endcase
        end
        default: begin
          byteWen   = 4'b0000;
          storeData = '0;
        end
      endcase
    end
  end

  // swl and swr are exclusive encodings
  always_comb begin
    if (storeType.dmWr) begin
      assert (storeType.leftOrRight != 2'b11)
        else $error("storeAlign: leftOrRight 11 on a store");
    end
  end

endmodule

`default_nettype wire

//--- memStagePkg.sv
// memory stage package with request structs, size codes and register offsets
`default_nettype none

package memStagePkg;

  // store size codes
  localparam logic [1:0] STORE_SW = 2'b00;
  localparam logic [1:0] STORE_SH = 2'b01;
  localparam logic [1:0] STORE_SB = 2'b10;

  // load size codes
  localparam logic [1:0] LOAD_LW = 2'b00;
  localparam logic [1:0] LOAD_LH = 2'b01;
  localparam logic [1:0] LOAD_LB = 2'b10;

  // apb register offsets
  localparam logic [3:0] REG_CTRL    = 4'h0;
  localparam logic [3:0] REG_ERRCNT  = 4'h4;
  localparam logic [3:0] REG_BADADDR = 4'h8;

  typedef struct packed {
    logic       dmWr;
    logic [1:0] leftOrRight; // 10 swl, 01 swr, 00 plain
    logic [1:0] size;
  } storeType_t;

  typedef struct packed {
    logic       dmRd;
    logic [1:0] leftOrRight; // 10 lwl, 01 lwr, 00 plain
    logic [1:0] size;
    logic       sign;        // 1 for lb/lh
  } loadType_t;

  typedef struct packed {
    logic [31:0] addr;
    storeType_t  storeType;
    loadType_t   loadType;
    logic [31:0] wdata;      // rt value for stores
    logic [31:0] rtOld;      // old rt for lwl/lwr
  } memReq_t;

  // held across the ram read cycle
  typedef struct packed {
    loadType_t   loadType;
    logic [1:0]  addrLow;
    logic [31:0] rtOld;
  } loadCtx_t;

endpackage

`default_nettype wire
